//--- dcache_geom_pkg.sv
// Cache geometry, address split and frame types that every dcache block imports
package dcache_geom_pkg;
    localparam int WORD_W     = 32;
    localparam int SETS       = 8;
    localparam int IDX_W      = 3;
    localparam int TAG_W      = 26;
    localparam int WAYS_SLOTS = 16;  // Way/set pairs walked on flush
    localparam int SLOT_W     = 4;

    // Byte address split into tag, index, word offset and byte
    localparam int TAG_HI  = 31;
    localparam int TAG_LO  = 6;
    localparam int IDX_HI  = 5;
    localparam int IDX_LO  = 3;
    localparam int OFS_BIT = 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [SLOT_W-1:0] slot_t;  // MSB is the way

    localparam word_t WORD1_OFS = 32'd4;  // Byte offset of second word

    typedef struct packed {
        logic        valid;
        logic        dirty;
        tag_t        tag;
        word_t [1:0] data;
    } frame_t;

    typedef struct packed {
        frame_t [1:0] way;
        logic         mru;  // Way used last
    } set_t;

    typedef enum logic [2:0] {
        ARR_IDLE, ARR_RD_HIT, ARR_WR_HIT, ARR_FILL0, ARR_FILL1, ARR_WB_DONE
    } arr_op_t;
endpackage

//--- dcache_bus_pkg.sv
// Processor and memory port structs of the dcache that the top level and the controller use
package dcache_bus_pkg;
    typedef struct packed {
        logic                   ren;
        logic                   wen;
        dcache_geom_pkg::word_t addr;
        dcache_geom_pkg::word_t store;
    } dp_req_t;

    typedef struct packed {
        logic                   hit;   // One-cycle strobe per request
        dcache_geom_pkg::word_t load;
        logic                   flushed;
    } dp_rsp_t;

    typedef struct packed {
        logic                   ren;
        logic                   wen;
        dcache_geom_pkg::word_t addr;
        dcache_geom_pkg::word_t store;
    } mem_req_t;

    typedef struct packed {
        logic                   dwait;  // High while transfer is pending
        dcache_geom_pkg::word_t load;
    } mem_rsp_t;
endpackage

//--- dcache_lookup.sv
// Tag compare, hit way, victim choice and load word mux for the set addressed by the processor
`timescale 1ns/10ps

module dcache_lookup (
    input  dcache_geom_pkg::tag_t   tag_i,
    input  logic                    offset_i,
    input  dcache_geom_pkg::set_t   set_i,
    output logic                    hit_o,
    output logic                    hit_way_o,
    output logic                    victim_way_o,
    output dcache_geom_pkg::frame_t victim_o,
    output dcache_geom_pkg::word_t  rdata_o
);
    logic [1:0] match;

    assign match[0] = set_i.way[0].valid && (set_i.way[0].tag == tag_i);
    assign match[1] = set_i.way[1].valid && (set_i.way[1].tag == tag_i);

    assign hit_o        = |match;
    assign hit_way_o    = match[1];
    assign victim_way_o = ~set_i.mru;  // LRU of two ways
    assign victim_o     = set_i.way[victim_way_o];
    assign rdata_o      = set_i.way[hit_way_o].data[offset_i];

    // A block is only ever installed into one way of a set
    always_comb begin
        single_way_match: assert (match != 2'b11)
            else $error("both ways of a set hold the same tag");
    end
endmodule

//--- dcache_array.sv
// Frame and MRU storage of the dcache, updated by commands from the controller
`timescale 1ns/10ps

module dcache_array (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_geom_pkg::idx_t    index_i,
    output dcache_geom_pkg::set_t    set_o,
    input  dcache_geom_pkg::slot_t   slot_i,
    output dcache_geom_pkg::frame_t  slot_frame_o,
    input  dcache_geom_pkg::arr_op_t op_i,
    input  logic                     way_i,
    input  logic                     offset_i,
    input  dcache_geom_pkg::tag_t    tag_i,
    input  dcache_geom_pkg::word_t   wdata_i
);
    import dcache_geom_pkg::*;

    set_t [SETS-1:0] sets_q;
    frame_t          tgt;  // Frame named by index and way

    assign set_o        = sets_q[index_i];
    assign slot_frame_o = sets_q[slot_i[IDX_W-1:0]].way[slot_i[SLOT_W-1]];
    assign tgt          = set_o.way[way_i];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sets_q <= '0;
        end else begin
            case (op_i)
                ARR_RD_HIT: begin
                    sets_q[index_i].mru <= way_i;
                end
                ARR_WR_HIT: begin
                    sets_q[index_i].way[way_i].data[offset_i] <= wdata_i;
                    sets_q[index_i].way[way_i].dirty <= 1'b1;
                    sets_q[index_i].mru <= way_i;
                end
                ARR_FILL0: begin
                    sets_q[index_i].way[way_i].data[0] <= wdata_i;
                end
                ARR_FILL1: begin
                    sets_q[index_i].way[way_i].data[1] <= wdata_i;
                    sets_q[index_i].way[way_i].valid <= 1'b1;
                    sets_q[index_i].way[way_i].dirty <= 1'b0;  // Fills are clean
                    sets_q[index_i].way[way_i].tag <= tag_i;
                end
                ARR_WB_DONE: begin
                    sets_q[index_i].way[way_i].valid <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // Dirty victim must be written back before its frame is refilled
    fill_after_writeback: assert property (@(posedge CLK) disable iff (!nRST)
        (op_i inside {ARR_FILL0, ARR_FILL1}) |-> !(tgt.valid && tgt.dirty))
        else $error("fill into a valid dirty frame");
endmodule

//--- flush_counter.sv
// Walks the way/set slots one by one while the dcache flushes on halt
`timescale 1ns/10ps

module flush_counter (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   advance_i,
    output dcache_geom_pkg::slot_t slot_o,
    output logic                   last_o
);
    import dcache_geom_pkg::*;

    logic [SLOT_W:0] cnt_q;  // Extra bit marks all slots done

    assign slot_o = cnt_q[SLOT_W-1:0];
    assign last_o = (cnt_q == (SLOT_W+1)'(WAYS_SLOTS));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt_q <= '0;
        end else if (advance_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Controller stops walking once every slot is consumed
    no_advance_past_end: assert property (@(posedge CLK) disable iff (!nRST)
        last_o |-> !advance_i)
        else $error("flush counter advanced past last slot");
endmodule

//--- dcache_ctrl.sv
// Miss, writeback and halt flush FSM of the dcache; drives the memory port and array commands
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      halt_i,
    input  dcache_bus_pkg::dp_req_t   dp_req_i,
    output dcache_bus_pkg::dp_rsp_t   dp_rsp_o,
    input  logic                      hit_i,
    input  logic                      hit_way_i,
    input  logic                      victim_way_i,
    input  dcache_geom_pkg::frame_t   victim_i,
    input  dcache_geom_pkg::word_t    rdata_i,
    input  dcache_geom_pkg::frame_t   slot_frame_i,
    input  dcache_geom_pkg::slot_t    slot_i,
    input  logic                      last_i,
    output logic                      advance_o,
    output dcache_geom_pkg::arr_op_t  op_o,
    output logic                      way_o,
    output dcache_geom_pkg::word_t    wdata_o,
    output dcache_bus_pkg::mem_req_t  mem_req_o,
    input  dcache_bus_pkg::mem_rsp_t  mem_rsp_i
);
    import dcache_geom_pkg::*;

    typedef enum logic [3:0] {
        IDLE, CHECK, WB1, WB2, FILL1, FILL2, FLUSH_CHECK, FLUSH_WB1, FLUSH_WB2, DONE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   req;
    logic   xfer_done;
    word_t  blk_base;     // Fill address of the request block
    word_t  victim_base;
    word_t  slot_base;

    assign req         = dp_req_i.ren || dp_req_i.wen;
    assign xfer_done   = !mem_rsp_i.dwait;
    assign blk_base    = {dp_req_i.addr[TAG_HI:IDX_LO], 3'b000};
    assign victim_base = {victim_i.tag, dp_req_i.addr[IDX_HI:IDX_LO], 3'b000};
    assign slot_base   = {slot_frame_i.tag, slot_i[IDX_W-1:0], 3'b000};

    always_comb begin
        state_d          = state_q;
        op_o             = ARR_IDLE;
        way_o            = victim_way_i;
        wdata_o          = mem_rsp_i.load;
        advance_o        = 1'b0;
        mem_req_o        = '0;
        dp_rsp_o.hit     = 1'b0;
        dp_rsp_o.load    = rdata_i;
        dp_rsp_o.flushed = 1'b0;
        case (state_q)
            IDLE: begin
                if (halt_i) begin
                    state_d = FLUSH_CHECK;
                end else if (req && hit_i) begin
                    dp_rsp_o.hit = 1'b1;
                    op_o    = dp_req_i.wen ? ARR_WR_HIT : ARR_RD_HIT;
                    way_o   = hit_way_i;
                    wdata_o = dp_req_i.store;
                end else if (req) begin
                    state_d = CHECK;
                end
            end
            CHECK: begin
                state_d = (victim_i.valid && victim_i.dirty) ? WB1 : FILL1;
            end
            WB1, WB2: begin
                mem_req_o.wen   = 1'b1;
                mem_req_o.addr  = (state_q == WB2) ? (victim_base | WORD1_OFS) : victim_base;
                mem_req_o.store = victim_i.data[state_q == WB2];
                if (xfer_done) begin
                    state_d = (state_q == WB2) ? FILL1 : WB2;
                    op_o    = (state_q == WB2) ? ARR_WB_DONE : ARR_IDLE;
                end
            end
            FILL1, FILL2: begin
                mem_req_o.ren  = 1'b1;
                mem_req_o.addr = (state_q == FILL2) ? (blk_base | WORD1_OFS) : blk_base;
                if (xfer_done) begin
                    state_d = (state_q == FILL2) ? IDLE : FILL2;  // Hit strobes from IDLE
                    op_o    = (state_q == FILL2) ? ARR_FILL1 : ARR_FILL0;
                end
            end
            FLUSH_CHECK: begin
                if (last_i) begin
                    state_d = DONE;
                end else if (slot_frame_i.valid && slot_frame_i.dirty) begin
                    state_d = FLUSH_WB1;
                end else begin
                    advance_o = 1'b1;  // Skip clean slot
                end
            end
            FLUSH_WB1, FLUSH_WB2: begin
                mem_req_o.wen   = 1'b1;
                mem_req_o.addr  = (state_q == FLUSH_WB2) ? (slot_base | WORD1_OFS) : slot_base;
                mem_req_o.store = slot_frame_i.data[state_q == FLUSH_WB2];
                if (xfer_done) begin
                    state_d   = (state_q == FLUSH_WB2) ? FLUSH_CHECK : FLUSH_WB2;
                    advance_o = (state_q == FLUSH_WB2);
                end
            end
            DONE: begin
                dp_rsp_o.flushed = 1'b1;  // Held until reset
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    one_mem_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req_o.ren && mem_req_o.wen))
        else $error("memory read and write raised together");

    // Request fields hold while memory stalls
    hold_under_wait: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req_o.ren || mem_req_o.wen) && mem_rsp_i.dwait |=> $stable(mem_req_o))
        else $error("memory request changed under wait");
endmodule

//--- dcache.sv
// Two-way write-back data cache top level; the processor and memory attach to its struct ports
`timescale 1ns/10ps

module dcache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     halt_i,
    input  dcache_bus_pkg::dp_req_t  dp_req_i,
    output dcache_bus_pkg::dp_rsp_t  dp_rsp_o,
    output dcache_bus_pkg::mem_req_t mem_req_o,
    input  dcache_bus_pkg::mem_rsp_t mem_rsp_i
);
    import dcache_geom_pkg::*;

    set_t    cur_set;
    frame_t  victim;
    frame_t  slot_frame;
    word_t   rdata;
    word_t   wdata;
    slot_t   slot;
    arr_op_t op;
    logic    hit;
    logic    hit_way;
    logic    victim_way;
    logic    way;
    logic    last;
    logic    advance;

    dcache_ctrl u_ctrl (
        .CLK, .nRST, .halt_i, .dp_req_i, .dp_rsp_o,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way), .victim_i(victim),
        .rdata_i(rdata), .slot_frame_i(slot_frame), .slot_i(slot), .last_i(last),
        .advance_o(advance), .op_o(op), .way_o(way), .wdata_o(wdata),
        .mem_req_o, .mem_rsp_i
    );

    flush_counter u_flush_cnt (
        .CLK, .nRST, .advance_i(advance), .slot_o(slot), .last_o(last)
    );

    dcache_lookup u_lookup (
        .tag_i(dp_req_i.addr[TAG_HI:TAG_LO]), .offset_i(dp_req_i.addr[OFS_BIT]),
        .set_i(cur_set), .hit_o(hit), .hit_way_o(hit_way),
        .victim_way_o(victim_way), .victim_o(victim), .rdata_o(rdata)
    );

    dcache_array u_array (
        .CLK, .nRST, .index_i(dp_req_i.addr[IDX_HI:IDX_LO]), .set_o(cur_set),
        .slot_i(slot), .slot_frame_o(slot_frame), .op_i(op), .way_i(way),
        .offset_i(dp_req_i.addr[OFS_BIT]), .tag_i(dp_req_i.addr[TAG_HI:TAG_LO]),
        .wdata_i(wdata)
    );
endmodule

//--- tb_dcache.sv
// Random read/write testbench for the dcache with a waiting memory model and a reference image
`timescale 1ns/10ps

module tb_dcache;
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DLY       = 1;
    localparam int RESET_CYCLES    = 5;
    localparam int N_OPS           = 400;
    localparam int MAX_DELAY       = 3;   // Max wait cycles per word transfer
    localparam int N_BLOCKS        = 24;
    localparam int MEM_WORDS       = 64;
    localparam int WATCHDOG_CYCLES = N_OPS * MAX_DELAY * 8;
    localparam int SEED            = 32'h6f0c;

    logic     CLK;
    logic     nRST;
    logic     halt;
    dp_req_t  dp_req;
    dp_rsp_t  dp_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    word_t    backing [MEM_WORDS];
    word_t    ref_mem [MEM_WORDS];  // What every address should read
    int       n_errors;
    int       n_checks;
    logic     xfer_busy;
    int       wait_left;
    logic     hold_pending;
    mem_req_t held_req;

    dcache uut (
        .CLK, .nRST, .halt_i(halt), .dp_req_i(dp_req), .dp_rsp_o(dp_rsp),
        .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Packs tag bits 9:6, set bit 3 and word bit 2 into a 6-bit memory index
    function automatic int mem_index(input word_t addr);
        return int'(addr[TAG_LO +: 4]) * 4 + int'(addr[IDX_LO]) * 2 + int'(addr[OFS_BIT]);
    endfunction

    function automatic logic addr_ok(input word_t addr);
        return addr[31:10] == '0 && addr[IDX_HI:IDX_LO+1] == '0 && addr[1:0] == '0
            && addr[TAG_LO +: 4] < 4'd12;
    endfunction

    function automatic word_t make_addr(input int blk, input int word_sel);
        word_t addr;
        addr = '0;
        addr[TAG_LO +: 4] = 4'(blk / 2);
        addr[IDX_LO]      = 1'(blk % 2);  // Sets 0 and 1 only
        addr[OFS_BIT]     = 1'(word_sel);
        return addr;
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    task automatic report_failure(input string msg);
        n_errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_image(input word_t got [MEM_WORDS], input word_t exp [MEM_WORDS]);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("backing[%0d]", i), got[i], exp[i]);
        end
    endtask

    task automatic check_idle_outputs(input string when);
        if (mem_req.ren || mem_req.wen || dp_rsp.hit || dp_rsp.flushed) begin
            report_failure({"memory enable, hit or flushed high ", when});
        end
    endtask

    // Holds one request until the hit strobe, then updates or checks the reference
    task automatic cpu_access(input logic is_write, input word_t addr, input word_t data,
                              input logic expect_hit);
        int idx;
        bit first;
        bit done;
        idx   = mem_index(addr);
        first = 1'b1;
        done  = 1'b0;
        @(posedge CLK);
        #DRIVE_DLY;
        dp_req.ren   = !is_write;
        dp_req.wen   = is_write;
        dp_req.addr  = addr;
        dp_req.store = is_write ? data : '0;
        while (!done) begin
            @(negedge CLK);
            if (dp_rsp.hit) begin
                done = 1'b1;
                if (is_write) begin
                    ref_mem[idx] = data;
                end else begin
                    check_word("dp_rsp.load", dp_rsp.load, ref_mem[idx]);
                end
            end else if (first && expect_hit) begin
                report_failure($sformatf("read of resident block at %h missed", addr));
            end
            first = 1'b0;
        end
    endtask

    // Memory responder with a random wait count per transfer
    always begin
        @(posedge CLK);
        #DRIVE_DLY;
        if (xfer_busy && !mem_rsp.dwait) begin
            xfer_busy = 1'b0;  // Finished at this edge
        end
        if (!nRST || !(mem_req.ren || mem_req.wen)) begin
            xfer_busy = 1'b0;
            mem_rsp   = '0;
        end else begin
            if (!xfer_busy) begin
                xfer_busy = 1'b1;
                wait_left = int'($urandom % (MAX_DELAY + 1));
            end else begin
                wait_left--;
            end
            mem_rsp.dwait = (wait_left != 0);
            mem_rsp.load  = mem_req.ren ? backing[mem_index(mem_req.addr)] : '0;
        end
    end

    // Bus monitor; a transfer completes on the edge after a low-wait negedge
    always @(negedge CLK) begin
        if (nRST) begin
            if (hold_pending) begin
                if (mem_req.ren !== held_req.ren || mem_req.wen !== held_req.wen) begin
                    report_failure("memory read or write enable changed while wait was high");
                end
                check_word("mem_req.addr", mem_req.addr, held_req.addr);
                check_word("mem_req.store", mem_req.store, held_req.store);
            end
            hold_pending = (mem_req.ren || mem_req.wen) && mem_rsp.dwait;
            held_req     = mem_req;
            if ((mem_req.ren || mem_req.wen) && !mem_rsp.dwait) begin
                if (!addr_ok(mem_req.addr)) begin
                    report_failure($sformatf("memory access to unused address %h",
                                             mem_req.addr));
                end else if (mem_req.wen) begin
                    check_word("mem_req.store", mem_req.store,
                               ref_mem[mem_index(mem_req.addr)]);
                    backing[mem_index(mem_req.addr)] = mem_req.store;
                end
            end
            if (dp_rsp.flushed && !halt) begin
                report_failure("flushed raised without halt");
            end
            if (dp_rsp.flushed && mem_req.wen) begin
                report_failure("memory write after flushed rose");
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the cache stopped making progress",
                 WATCHDOG_CYCLES);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        word_t addr;
        int    blk;
        int    last_blk;
        logic  is_write;
        void'($urandom(SEED));
        nRST         = 1'b0;
        halt         = 1'b0;
        dp_req       = '0;
        mem_rsp      = '0;
        n_errors     = 0;
        n_checks     = 0;
        xfer_busy    = 1'b0;
        wait_left    = 0;
        hold_pending = 1'b0;
        held_req     = '0;
        last_blk     = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            backing[i] = fill_word(make_addr(i / 2, i % 2));
            ref_mem[i] = backing[i];
        end
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            check_idle_outputs("during reset");
        end
        @(posedge CLK);
        #DRIVE_DLY nRST = 1'b1;
        @(negedge CLK);
        check_idle_outputs("right after reset");

        for (int op = 0; op < N_OPS; op++) begin
            if (op > 0 && ($urandom % 4) == 0) begin
                addr = make_addr(last_blk, int'($urandom % 2));
                cpu_access(1'b0, addr, '0, 1'b1);  // Same block as last access
            end else begin
                blk      = int'($urandom % N_BLOCKS);
                is_write = ($urandom % 2) == 1;
                addr     = make_addr(blk, int'($urandom % 2));
                cpu_access(is_write, addr, $urandom, 1'b0);
                last_blk = blk;
            end
        end

        @(posedge CLK);
        #DRIVE_DLY;
        dp_req = '0;
        halt   = 1'b1;
        do @(negedge CLK); while (!dp_rsp.flushed);
        repeat (8) begin
            @(negedge CLK);
            if (!dp_rsp.flushed) begin
                report_failure("flushed dropped after rising");
            end
        end
        check_image(backing, ref_mem);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule

//--- verilog.f
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_lookup.sv
dcache_array.sv
flush_counter.sv
dcache_ctrl.sv
dcache.sv
tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
